//--- files.f
common/multicore_pkg.sv
hw/reset_sequencer.sv
core/compute_core.sv
hw/sample_fifo.sv
hw/input_arbiter.sv
hw/output_collector.sv
hw/wb_host_port.sv
hw/multicore_array.sv
verification/multicore_asserts.sv
verification/multicore_checker.sv
verification/multicore_tb.sv

//--- verification/multicore_tb.sv
`timescale 1ns/10ps
`default_nettype none

module multicore_tb import multicore_pkg::*; ();

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	int          chk_errors;
	logic        aborted;
	int          n_written;
	int          owed;  // Jobs written but not read back

	multicore_array dut (
		.clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
	);

	multicore_checker chk (
		.clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.errors(chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_wait(input string what);
		if (!aborted)
			chk.note_failure({"Timed out waiting for ", what});
		aborted = 1'b1;
	endtask

	// ====================
	// Wishbone host
	task automatic bus_xfer(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		input int limit, output logic acked, output logic [31:0] rdata);
		int waited;
		acked  = 1'b0;
		rdata  = '0;
		waited = 0;
		if (aborted)
			return;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = {adr, 2'b00};
		wb_dat_w = wdata;
		while (!acked && waited < limit) begin
			@(negedge clk);
			waited++;
			if (wb_ack) begin
				acked = 1'b1;
				rdata = wb_dat_r;
			end
		end
		if (acked)
			@(negedge clk);  // Hold stb across the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] rdata);
		logic acked;
		bus_xfer(1'b0, adr, '0, 20, acked, rdata);
		if (!acked)
			fail_wait("wb_ack on a register read");
	endtask

	task automatic try_write(input sample_t s, input int limit, output logic acked);
		logic [31:0] rdata_unused;
		bus_xfer(1'b1, ADDR_SAMPLE, {16'h0, s}, limit, acked, rdata_unused);
		if (acked) begin
			n_written++;
			if (n_written % JOB_LEN == 0)
				owed++;
		end
	endtask

	task automatic write_samples(input int count);
		logic acked;
		for (int i = 0; i < count && !aborted; i++) begin
			try_write(16'($urandom), 200, acked);
			if (!acked)
				fail_wait("wb_ack on a SAMPLE write");
		end
	endtask

	task automatic read_result(output logic valid);
		logic [31:0] word;
		read_reg(ADDR_RESULT, word);
		valid = word[31];
		if (valid)
			owed--;
	endtask

	task automatic drain_results();
		logic valid;
		int   reads;
		reads = 0;
		while (!aborted && owed > 0 && reads < 600) begin
			read_result(valid);
			reads++;
		end
		if (owed > 0)
			fail_wait("all results to come back");
	endtask

	initial begin
		logic [31:0] word;
		logic        acked;
		logic        valid;
		logic        stalled;
		sample_t     s;
		int          polls;
		int          tries;
		void'($urandom(32'h8b6f0faf));
		arst_n    = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		aborted   = 1'b0;
		n_written = 0;
		owed      = 0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;

		// ====================
		// Staggered start
		word  = '0;
		polls = 0;
		while (!aborted && polls < 200 && word[STATUS_RUN_LSB +: RUN_W] != RUN_W'(N_CORES)) begin
			read_reg(ADDR_STATUS, word);
			polls++;
		end
		if (word[STATUS_RUN_LSB +: RUN_W] != RUN_W'(N_CORES))
			fail_wait("all cores to run");
		chk.check_idle_status();
		chk.finish_test("staggered_start");

		write_samples(JOB_LEN);
		drain_results();
		chk.check_drained();
		chk.finish_test("single_job");

		write_samples(64);
		drain_results();
		chk.check_drained();
		chk.finish_test("many_jobs");

		read_reg(ADDR_RESULT, word);
		chk.check_empty_read();
		chk.finish_test("empty_read");

		// ====================
		// Back-pressure, reads only once a write stalls
		stalled = 1'b0;
		for (int i = 0; i < 120 && !aborted; i++) begin
			s     = 16'($urandom);
			tries = 0;
			acked = 1'b0;
			while (!aborted && !acked) begin
				try_write(s, 40, acked);
				if (!acked) begin
					stalled = 1'b1;
					tries++;
					read_reg(ADDR_STATUS, word);  // Both FIFOs near full here
					read_result(valid);
					read_result(valid);
					if (tries > 20)
						fail_wait("a stalled SAMPLE write to complete");
				end
			end
			if (i % 8 == 7)
				read_reg(ADDR_STATUS, word);
		end
		if (!stalled && !aborted)
			chk.note_failure("No SAMPLE write stalled while results were not read");
		drain_results();
		chk.check_drained();
		read_reg(ADDR_STATUS, word);
		chk.check_idle_status();
		chk.finish_test("back_pressure");

		chk.report_totals(dut.u_asserts.fail_count);
		if (chk_errors == 0 && dut.u_asserts.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/multicore_checker.sv
`timescale 1ns/10ps
`default_nettype none

module multicore_checker import multicore_pkg::*; (
	input  wire logic        clk,
	input  wire logic        arst_n,
	input  wire logic        wb_cyc,
	input  wire logic        wb_stb,
	input  wire logic        wb_we,
	input  wire logic [3:0]  wb_adr,
	input  wire logic [31:0] wb_dat_w,
	input  wire logic [31:0] wb_dat_r,
	input  wire logic        wb_ack,
	output int               errors
);

	int          grp_idx_q[$];  // Full groups still owed a result
	int          grp_sum_q[$];
	int          n_groups;
	int          part_sum;
	int          part_cnt;
	int          checks;
	int          test_checks;
	int          test_errors;
	logic [31:0] last_status;
	logic [31:0] last_result;

	initial begin
		errors      = 0;
		n_groups    = 0;
		part_sum    = 0;
		part_cnt    = 0;
		checks      = 0;
		test_checks = 0;
		test_errors = 0;
		last_status = '0;
		last_result = '0;
	end

	task automatic add_sample(input logic [15:0] s);
		part_sum += $signed(s);
		part_cnt++;
		if (part_cnt == JOB_LEN) begin
			grp_idx_q.push_back(n_groups);
			grp_sum_q.push_back(part_sum);
			n_groups++;
			part_sum = 0;
			part_cnt = 0;
		end
	endtask

	// Same tag can be pending twice after the wrap, oldest match wins
	task automatic check_result(input logic [31:0] word);
		int tag;
		int core;
		int got;
		int hit;
		int oldest;
		tag    = word[27:24];
		core   = word[30:28];
		got    = $signed(word[23:0]);
		hit    = -1;
		oldest = -1;
		foreach (grp_idx_q[i]) begin
			if (grp_idx_q[i] % (1 << JOB_TAG_W) == tag) begin
				if (oldest < 0)
					oldest = i;
				if (hit < 0 && grp_sum_q[i] * (core + 1) == got)
					hit = i;
			end
		end
		checks++;
		if (oldest < 0) begin
			$display("Result with tag %0d from core %0d matches no pending job", tag, core);
			errors++;
		end else begin
			if (hit < 0) begin
				$display("[ERROR] wb_dat_r.sum exp %h got %h",
					24'(grp_sum_q[oldest] * (core + 1)), word[23:0]);
				errors++;
				hit = oldest;
			end
			grp_idx_q.delete(hit);
			grp_sum_q.delete(hit);
		end
	endtask

	task automatic check_status(input logic [31:0] s);
		checks++;
		if (s[STATUS_RUN_LSB +: RUN_W] < last_status[STATUS_RUN_LSB +: RUN_W]) begin
			$display("[ERROR] status.running exp >= %h got %h",
				last_status[STATUS_RUN_LSB +: RUN_W], s[STATUS_RUN_LSB +: RUN_W]);
			errors++;
		end
		if (s[STATUS_SLVL_LSB +: LEVEL_W] > FIFO_DEPTH) begin
			$display("[ERROR] status.sample_level exp <= %h got %h",
				FIFO_DEPTH, s[STATUS_SLVL_LSB +: LEVEL_W]);
			errors++;
		end
		if (s[STATUS_RLVL_LSB +: LEVEL_W] > FIFO_DEPTH) begin
			$display("[ERROR] status.result_level exp <= %h got %h",
				FIFO_DEPTH, s[STATUS_RLVL_LSB +: LEVEL_W]);
			errors++;
		end
		last_status = s;
	endtask

	// ====================
	// Bus monitor
	always @(posedge clk) begin
		if (arst_n && wb_cyc && wb_stb && wb_ack) begin
			case (wb_adr[3:2])
				ADDR_SAMPLE: begin
					if (wb_we)
						add_sample(wb_dat_w[15:0]);
				end
				ADDR_RESULT: begin
					if (!wb_we) begin
						last_result = wb_dat_r;
						if (wb_dat_r[31])
							check_result(wb_dat_r);
					end
				end
				ADDR_STATUS: begin
					if (!wb_we)
						check_status(wb_dat_r);
				end
				default: ;
			endcase
		end
	end

	task automatic check_idle_status();
		checks++;
		if (last_status[STATUS_RUN_LSB +: RUN_W] != RUN_W'(N_CORES)) begin
			$display("[ERROR] status.running exp %h got %h",
				RUN_W'(N_CORES), last_status[STATUS_RUN_LSB +: RUN_W]);
			errors++;
		end
		if (last_status[STATUS_SLVL_LSB +: LEVEL_W] != 0
			|| last_status[STATUS_RLVL_LSB +: LEVEL_W] != 0) begin
			$display("[ERROR] status levels exp %h got %h", 32'h0,
				last_status & 32'h000f_0f00);
			errors++;
		end
	endtask

	task automatic check_drained();
		checks++;
		if (grp_idx_q.size() != 0 || part_cnt != 0) begin
			$display("%0d jobs never came back as results", grp_idx_q.size());
			errors++;
		end
	endtask

	task automatic check_empty_read();
		checks++;
		if (last_result != '0) begin
			$display("[ERROR] wb_dat_r exp %h got %h", 32'h0, last_result);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic report_totals(input int assert_fails);
		$display("total: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_fails);
	endtask

endmodule

`default_nettype wire

//--- verification/multicore_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module multicore_asserts import multicore_pkg::*; (
	input wire logic               clk,
	input wire logic               arst_n,
	input wire logic               wb_cyc,
	input wire logic               wb_stb,
	input wire logic               wb_ack,
	input wire logic [N_CORES-1:0] core_req,
	input wire logic [N_CORES-1:0] core_grant,
	input wire logic [N_CORES-1:0] out_en,
	input wire logic [N_CORES-1:0] out_ack
);

	int fail_count = 0;

	grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(core_grant))
		else begin
			fail_count++;
			$error("core_grant not one-hot: %h", core_grant);
		end

	grant_to_req: assert property (@(posedge clk) disable iff (!arst_n)
		(core_grant & ~core_req) == '0)
		else begin
			fail_count++;
			$error("core_grant %h to a core without req %h", core_grant, core_req);
		end

	ack_with_stb: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |-> wb_cyc && wb_stb)
		else begin
			fail_count++;
			$error("wb_ack without an open transfer");
		end

	// ====================
	// Cores keep out_en until taken
	for (genvar i = 0; i < N_CORES; i++) begin : g_hold
		out_en_hold: assert property (@(posedge clk) disable iff (!arst_n)
			out_en[i] && !out_ack[i] |=> out_en[i])
			else begin
				fail_count++;
				$error("out_en[%0d] dropped before out_ack", i);
			end
	end

endmodule

bind multicore_array multicore_asserts u_asserts (
	.clk, .arst_n, .wb_cyc, .wb_stb, .wb_ack, .core_req, .core_grant, .out_en, .out_ack
);

`default_nettype wire

//--- hw/multicore_array.sv
`timescale 1ns/10ps
`default_nettype none

module multicore_array import multicore_pkg::*; (
	input  wire logic        clk,
	input  wire logic        arst_n,
	input  wire logic        wb_cyc,
	input  wire logic        wb_stb,
	input  wire logic        wb_we,
	input  wire logic [3:0]  wb_adr,
	input  wire logic [31:0] wb_dat_w,
	output logic [31:0]      wb_dat_r,
	output logic             wb_ack
);

	logic                       sample_push;
	logic                       sample_full;
	logic                       sample_pop;
	logic                       sample_empty;
	sample_t                    sample_wdata;
	sample_t                    sample_rdata;
	logic [LEVEL_W-1:0]         sample_level;
	logic                       result_push;
	logic                       result_full;
	logic                       result_pop;
	logic                       result_empty;
	result_word_t               result_wdata;
	result_word_t               result_rdata;
	logic [LEVEL_W-1:0]         result_level;
	logic [N_CORES-1:0]         core_rst_n;
	logic [RUN_W-1:0]           running;
	logic [N_CORES-1:0]         core_req;
	logic [N_CORES-1:0]         core_grant;
	sample_t                    grant_sample;
	logic                       grant_first;
	logic [JOB_TAG_W-1:0]       grant_tag;
	logic [N_CORES-1:0]         out_en;
	logic [N_CORES-1:0]         out_ack;
	logic signed [RESULT_W-1:0] core_results [N_CORES];
	logic [JOB_TAG_W-1:0]       core_tags [N_CORES];

	wb_host_port u_host (.*);

	sample_fifo #(.payload_t(sample_t), .DEPTH(FIFO_DEPTH)) u_sample_fifo (
		.clk, .arst_n,
		.push(sample_push), .wdata(sample_wdata), .full(sample_full),
		.pop(sample_pop), .rdata(sample_rdata), .empty(sample_empty), .level(sample_level)
	);

	sample_fifo #(.payload_t(result_word_t), .DEPTH(FIFO_DEPTH)) u_result_fifo (
		.clk, .arst_n,
		.push(result_push), .wdata(result_wdata), .full(result_full),
		.pop(result_pop), .rdata(result_rdata), .empty(result_empty), .level(result_level)
	);

	reset_sequencer u_rst_seq (.clk, .arst_n, .core_rst_n, .running);

	input_arbiter u_arbiter (
		.clk, .arst_n, .core_req,
		.fifo_empty(sample_empty), .fifo_data(sample_rdata), .fifo_pop(sample_pop),
		.core_grant, .grant_sample, .grant_first, .grant_tag
	);

	// ====================
	// Core array
	for (genvar i = 0; i < N_CORES; i++) begin : g_core
		compute_core #(.CORE_ID(i)) u_core (
			.clk, .arst_n, .run_n(core_rst_n[i]), .req(core_req[i]),
			.grant(core_grant[i]), .sample(grant_sample), .first(grant_first), .tag(grant_tag),
			.out_en(out_en[i]), .result(core_results[i]), .result_tag(core_tags[i]),
			.out_ack(out_ack[i])
		);
	end

	output_collector u_collector (
		.clk, .arst_n, .out_en, .results(core_results), .result_tags(core_tags), .out_ack,
		.fifo_full(result_full), .fifo_push(result_push), .fifo_wdata(result_wdata)
	);

endmodule

`default_nettype wire

//--- hw/wb_host_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_host_port import multicore_pkg::*; (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               wb_cyc,
	input  wire logic               wb_stb,
	input  wire logic               wb_we,
	input  wire logic [3:0]         wb_adr,
	input  wire logic [31:0]        wb_dat_w,
	output logic [31:0]             wb_dat_r,
	output logic                    wb_ack,
	input  wire logic               sample_full,
	output logic                    sample_push,
	output sample_t                 sample_wdata,
	input  wire logic               result_empty,
	input  wire result_word_t       result_rdata,
	output logic                    result_pop,
	input  wire logic [RUN_W-1:0]   running,
	input  wire logic [LEVEL_W-1:0] sample_level,
	input  wire logic [LEVEL_W-1:0] result_level
);

	logic        xfer;
	logic [1:0]  word_adr;
	logic        sample_wr;
	logic        ack_next;
	logic [31:0] rdata_next;
	logic [31:0] status;

	assign xfer      = wb_cyc && wb_stb && !wb_ack;  // One idle cycle after each ack
	assign word_adr  = wb_adr[3:2];
	assign sample_wr = xfer && wb_we && (word_adr == ADDR_SAMPLE);

	always_comb begin
		status = '0;
		status[STATUS_RUN_LSB  +: RUN_W]   = running;
		status[STATUS_SLVL_LSB +: LEVEL_W] = sample_level;
		status[STATUS_RLVL_LSB +: LEVEL_W] = result_level;
	end

	// ====================
	// Address decode
	always_comb begin
		ack_next   = xfer;
		rdata_next = '0;
		result_pop = 1'b0;
		if (xfer) begin
			case (word_adr)
				ADDR_SAMPLE: ack_next = !wb_we || !sample_full;  // Stall while full
				ADDR_RESULT: begin
					if (!wb_we && !result_empty) begin
						result_pop = 1'b1;
						rdata_next = result_rdata;
					end
				end
				ADDR_STATUS: rdata_next = status;
				default:     rdata_next = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack      <= 1'b0;
			sample_push <= 1'b0;
		end else begin
			wb_ack      <= ack_next;
			sample_push <= sample_wr && !sample_full;  // Lands in the ack cycle
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			wb_dat_r     <= rdata_next;
			sample_wdata <= sample_t'(wb_dat_w[SAMPLE_W-1:0]);
		end
	end

endmodule

`default_nettype wire

//--- hw/output_collector.sv
`timescale 1ns/10ps
`default_nettype none

module output_collector import multicore_pkg::*; (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [N_CORES-1:0]         out_en,
	input  wire logic signed [RESULT_W-1:0] results [N_CORES],
	input  wire logic [JOB_TAG_W-1:0]       result_tags [N_CORES],
	output logic [N_CORES-1:0]              out_ack,
	input  wire logic                       fifo_full,
	output logic                            fifo_push,
	output result_word_t                    fifo_wdata
);

	logic [CORE_ID_W-1:0] sel;
	logic                 hit;
	logic                 take;

	// ====================
	// Lowest index wins
	always_comb begin
		sel = '0;
		hit = 1'b0;
		for (int i = N_CORES - 1; i >= 0; i--) begin
			if (out_en[i]) begin
				sel = CORE_ID_W'(i);
				hit = 1'b1;
			end
		end
	end

	// No pick during an ack cycle, the acked core still shows out_en
	assign take = hit && !fifo_full && !fifo_push;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_ack   <= '0;
			fifo_push <= 1'b0;
		end else begin
			out_ack   <= take ? (N_CORES'(1) << sel) : '0;
			fifo_push <= take;  // Same cycle as the ack
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			fifo_wdata <= '{
				valid: 1'b1,
				core:  sel,
				tag:   result_tags[sel],
				sum:   results[sel]
			};
		end
	end

endmodule

`default_nettype wire

//--- hw/input_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module input_arbiter import multicore_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic [N_CORES-1:0]   core_req,
	input  wire logic                 fifo_empty,
	input  wire sample_t              fifo_data,
	output logic                      fifo_pop,
	output logic [N_CORES-1:0]        core_grant,
	output sample_t                   grant_sample,
	output logic                      grant_first,
	output logic [JOB_TAG_W-1:0]      grant_tag
);

	logic [CORE_ID_W-1:0] rr_ptr;
	logic [CORE_ID_W-1:0] owner;
	logic [CORE_ID_W-1:0] pick;
	logic [CORE_ID_W-1:0] cur_owner;
	logic                 pick_vld;
	logic                 locked;
	logic                 deliver;
	logic [JOB_CNT_W-1:0] cnt;
	logic [JOB_TAG_W-1:0] tag;

	// Round robin search starting at rr_ptr
	always_comb begin
		int unsigned idx;
		pick     = '0;
		pick_vld = 1'b0;
		for (int k = 0; k < N_CORES; k++) begin
			idx = (int'(rr_ptr) + k) % N_CORES;
			if (!pick_vld && core_req[idx]) begin
				pick     = CORE_ID_W'(idx);
				pick_vld = 1'b1;
			end
		end
	end

	assign cur_owner    = locked ? owner : pick;
	assign deliver      = (locked || pick_vld) && !fifo_empty;
	assign core_grant   = deliver ? (N_CORES'(1) << cur_owner) : '0;
	assign fifo_pop     = deliver;
	assign grant_sample = fifo_data;
	assign grant_first  = !locked;
	assign grant_tag    = tag;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr <= '0;
			owner  <= '0;
			locked <= 1'b0;
			cnt    <= '0;
			tag    <= '0;
		end else if (deliver) begin
			owner <= cur_owner;
			if (cnt == JOB_CNT_W'(JOB_LEN - 1)) begin  // Job done, release the lock
				cnt    <= '0;
				locked <= 1'b0;
				tag    <= tag + 1'b1;
				rr_ptr <= (cur_owner == CORE_ID_W'(N_CORES - 1)) ? '0 : cur_owner + 1'b1;
			end else begin
				cnt    <= cnt + 1'b1;
				locked <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo import multicore_pkg::*; #(
	parameter type payload_t = sample_t,
	parameter int  DEPTH     = FIFO_DEPTH
) (
	input  wire logic                     clk,
	input  wire logic                     arst_n,
	input  wire logic                     push,
	input  wire payload_t                 wdata,
	output logic                          full,
	input  wire logic                     pop,
	output payload_t                      rdata,
	output logic                          empty,
	output logic [$clog2(DEPTH+1)-1:0]    level
);

	payload_t                 mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                     do_push;
	logic                     do_pop;

	assign full    = (level == DEPTH);
	assign empty   = (level == 0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign rdata   = mem[rd_ptr];  // Valid whenever not empty

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				level <= level + 1'b1;
			else if (do_pop && !do_push)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

`default_nettype wire

//--- core/compute_core.sv
`timescale 1ns/10ps
`default_nettype none

module compute_core import multicore_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic                 run_n,
	output logic                      req,
	input  wire logic                 grant,
	input  wire sample_t              sample,
	input  wire logic                 first,
	input  wire logic [JOB_TAG_W-1:0] tag,
	output logic                      out_en,
	output logic signed [RESULT_W-1:0] result,
	output logic [JOB_TAG_W-1:0]      result_tag,
	input  wire logic                 out_ack
);

	typedef enum logic [1:0] {IDLE, COLLECT, HOLD} state_t;

	state_t                     state;
	logic [JOB_CNT_W-1:0]       cnt;
	logic signed [RESULT_W-1:0] acc;
	logic signed [RESULT_W-1:0] sum_next;
	logic                       last;

	// Weight is CORE_ID + 1, built from shifted copies
	function automatic logic signed [RESULT_W-1:0] scale(input logic signed [RESULT_W-1:0] s);
		logic [CORE_ID_W:0]         w;
		logic signed [RESULT_W-1:0] p;
		w = (CORE_ID_W + 1)'(CORE_ID + 1);
		p = '0;
		for (int b = 0; b <= CORE_ID_W; b++) begin
			if (w[b])
				p = p + (s <<< b);
		end
		return p;
	endfunction

	assign sum_next = first ? RESULT_W'(sample) : acc + RESULT_W'(sample);
	assign last     = (cnt == JOB_CNT_W'(JOB_LEN - 1));
	assign req      = (state == COLLECT);
	assign out_en   = (state == HOLD);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
		end else if (!run_n) begin  // Still held by the sequencer
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE:    state <= COLLECT;
				COLLECT: begin
					if (grant) begin
						cnt <= last ? '0 : cnt + 1'b1;
						if (last)
							state <= HOLD;
					end
				end
				HOLD:    if (out_ack) state <= COLLECT;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req && grant) begin
			acc <= sum_next;
			if (first)
				result_tag <= tag;
			if (last)
				result <= scale(sum_next);
		end
	end

endmodule

`default_nettype wire

//--- hw/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer import multicore_pkg::*; (
	input  wire logic           clk,
	input  wire logic           arst_n,
	output logic [N_CORES-1:0]  core_rst_n,
	output logic [RUN_W-1:0]    running
);

	logic [STAGGER_W-1:0] stagger_cnt;
	logic [RUN_W-1:0]     core_ptr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stagger_cnt <= STAGGER_W'(STAGGER_CYCLES - 1);  // Core 0 goes on first clock
			core_ptr    <= '0;
		end else if (core_ptr != RUN_W'(N_CORES)) begin
			if (stagger_cnt == STAGGER_W'(STAGGER_CYCLES - 1)) begin
				stagger_cnt <= '0;
				core_ptr    <= core_ptr + 1'b1;  // Release next core
			end else begin
				stagger_cnt <= stagger_cnt + 1'b1;
			end
		end
	end

	// Every core below the pointer is running
	always_comb begin
		for (int i = 0; i < N_CORES; i++) begin
			core_rst_n[i] = (core_ptr > RUN_W'(i));
		end
	end

	assign running = core_ptr;

endmodule

`default_nettype wire

//--- common/multicore_pkg.sv
`default_nettype none

package multicore_pkg;

	// ====================
	// Array sizing
	localparam int N_CORES        = 8;
	localparam int CORE_ID_W      = 3;
	localparam int RUN_W          = $clog2(N_CORES + 1);
	localparam int JOB_LEN        = 4;  // Samples per job
	localparam int JOB_CNT_W      = $clog2(JOB_LEN);
	localparam int STAGGER_CYCLES = 6;
	localparam int STAGGER_W      = $clog2(STAGGER_CYCLES);

	// ====================
	// Data widths
	localparam int SAMPLE_W   = 16;
	localparam int RESULT_W   = 24;
	localparam int JOB_TAG_W  = 4;  // Wraps at 16
	localparam int FIFO_DEPTH = 8;
	localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1);

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		logic                       valid;  // Bit 31
		logic [CORE_ID_W-1:0]       core;
		logic [JOB_TAG_W-1:0]       tag;
		logic signed [RESULT_W-1:0] sum;
	} result_word_t;

	// ====================
	// Host registers, word address on wb_adr[3:2]
	localparam logic [1:0] ADDR_SAMPLE = 2'd0;
	localparam logic [1:0] ADDR_RESULT = 2'd1;
	localparam logic [1:0] ADDR_STATUS = 2'd2;

	localparam int STATUS_RUN_LSB  = 0;
	localparam int STATUS_SLVL_LSB = 8;   // Sample FIFO level
	localparam int STATUS_RLVL_LSB = 16;  // Result FIFO level

endpackage

`default_nettype wire
